// File: Bender.yml
package:
  name: pong

sources:
  - pong_pkg.sv
  - vga_timing.sv
  - step_timer.sv
  - paddle_ctrl.sv
  - ball_ctrl.sv
  - pixel_render.sv
  - pong_top.sv
  - target: test
    files:
      - pong_properties.sv
      - tb_clock_gen.sv
      - tb_pong.sv

// File: ball_ctrl.sv
`timescale 1ns/100ps

module ball_ctrl (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         step,
	input  logic [pong_pkg::pos_w-1:0]   pad_col,
	output logic [pong_pkg::pos_w-1:0]   ball_row,
	output logic [pong_pkg::pos_w-1:0]   ball_col,
	output logic                         hit,
	output logic                         miss,
	output logic [pong_pkg::score_w-1:0] score
);

	logic [1:0] dir;
	logic       hit_q;
	logic       move_up;
	logic       move_right;
	logic       in_top;
	logic       in_left;
	logic       in_right;
	logic       in_bottom;
	logic       caught;

	assign move_up = (dir == pong_pkg::dir_up_right) || (dir == pong_pkg::dir_up_left);
	assign move_right = (dir == pong_pkg::dir_up_right) || (dir == pong_pkg::dir_down_right);

	// zone tests on the ball box edges
	assign in_top = (ball_row <= pong_pkg::top_bounce_row + pong_pkg::ball_half);
	assign in_left = (ball_col <= pong_pkg::field_left + pong_pkg::ball_half);
	assign in_right = (ball_col + pong_pkg::ball_half >= pong_pkg::field_right);
	assign in_bottom = (ball_row + pong_pkg::ball_half >= pong_pkg::bottom_row);

	// paddle centre within the catch window of the ball column
	assign caught = (ball_col + pong_pkg::catch_half >= pad_col) &&
		(ball_col <= pad_col + pong_pkg::catch_half);

	// edge checks in order top, left, right, bottom
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			dir <= pong_pkg::dir_down_right;
			hit <= 1'b0;
			miss <= 1'b0;
		end
		else if (in_top)
		begin
			case (dir)
				pong_pkg::dir_up_right: dir <= pong_pkg::dir_down_right;
				pong_pkg::dir_up_left:  dir <= pong_pkg::dir_down_left;
				default:                dir <= dir;
			endcase
		end
		else if (in_left)
		begin
			case (dir)
				pong_pkg::dir_up_left:   dir <= pong_pkg::dir_up_right;
				pong_pkg::dir_down_left: dir <= pong_pkg::dir_down_right;
				default:                 dir <= dir;
			endcase
		end
		else if (in_right)
		begin
			case (dir)
				pong_pkg::dir_up_right:   dir <= pong_pkg::dir_up_left;
				pong_pkg::dir_down_right: dir <= pong_pkg::dir_down_left;
				default:                  dir <= dir;
			endcase
		end
		else if (in_bottom)
		begin
			if (caught)
			begin
				case (dir)
					pong_pkg::dir_down_right: dir <= pong_pkg::dir_up_right;
					pong_pkg::dir_down_left:  dir <= pong_pkg::dir_up_left;
					default:                  dir <= dir;
				endcase
				hit <= 1'b1;
			end
			else
			begin
				miss <= 1'b1;
			end
		end
		else
		begin
			hit <= 1'b0;
			miss <= 1'b0;
		end
	end

	// one pixel diagonal per step, row back to start after a miss
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			ball_row <= pong_pkg::pos_w'(pong_pkg::ball_start_row);
			ball_col <= pong_pkg::pos_w'(pong_pkg::start_col);
		end
		else if (miss)
		begin
			ball_row <= pong_pkg::pos_w'(pong_pkg::ball_start_row);
		end
		else if (step)
		begin
			ball_row <= move_up ? ball_row - 1'b1 : ball_row + 1'b1;
			ball_col <= move_right ? ball_col + 1'b1 : ball_col - 1'b1;
		end
	end

	// score counts once per hit, on the falling edge of hit
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			hit_q <= 1'b0;
			score <= '0;
		end
		else
		begin
			hit_q <= hit;
			if (miss)
				score <= '0;
			else if (hit_q && !hit && score != '1)
				score <= score + 1'b1;
		end
	end

endmodule

// File: files.f
pong_pkg.sv
vga_timing.sv
step_timer.sv
paddle_ctrl.sv
ball_ctrl.sv
pixel_render.sv
pong_top.sv
pong_properties.sv
tb_clock_gen.sv
tb_pong.sv

// File: paddle_ctrl.sv
`timescale 1ns/100ps

module paddle_ctrl (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       left,
	input  logic                       right,
	input  logic                       step,
	output logic [pong_pkg::pos_w-1:0] pad_col
);

	logic at_left_edge;
	logic at_right_edge;

	// edge tests on the paddle extents, kept free of underflow
	assign at_left_edge = (pad_col <= pong_pkg::field_left + pong_pkg::pad_half_w);
	assign at_right_edge = (pad_col + pong_pkg::pad_half_w >= pong_pkg::field_right);

	// left wins when both buttons are held
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pad_col <= pong_pkg::pos_w'(pong_pkg::start_col);
		end
		else if (step && left)
		begin
			if (!at_left_edge)
				pad_col <= pad_col - pong_pkg::pos_w'(pong_pkg::pad_step);
		end
		else if (step && right)
		begin
			if (!at_right_edge)
				pad_col <= pad_col + pong_pkg::pos_w'(pong_pkg::pad_step);
		end
	end

endmodule

// File: pixel_render.sv
`timescale 1ns/100ps

module pixel_render (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [pong_pkg::coord_w-1:0] col,
	input  logic [pong_pkg::coord_w-1:0] row,
	input  logic [pong_pkg::pos_w-1:0]   ball_row,
	input  logic [pong_pkg::pos_w-1:0]   ball_col,
	input  logic [pong_pkg::pos_w-1:0]   pad_col,
	input  logic                         blink_a,
	input  logic                         blink_b,
	output logic                         vga_red,
	output logic                         vga_green,
	output logic                         vga_blue
);

	// pixel inside a box around a centre, edges included
	function automatic logic in_box(input int px, input int py, input int cx, input int cy,
		input int hw, input int hh);
		return (px >= cx - hw) && (px <= cx + hw) && (py >= cy - hh) && (py <= cy + hh);
	endfunction

	logic on_ball;
	logic on_player;
	logic on_cpu;

	assign on_ball = in_box(int'(col), int'(row), int'(ball_col), int'(ball_row),
		pong_pkg::ball_half, pong_pkg::ball_half);
	assign on_player = in_box(int'(col), int'(row), int'(pad_col), pong_pkg::player_row,
		pong_pkg::pad_half_w, pong_pkg::pad_half_h);
	// cpu paddle tracks the ball column
	assign on_cpu = in_box(int'(col), int'(row), int'(ball_col), pong_pkg::cpu_row,
		pong_pkg::pad_half_w, pong_pkg::pad_half_h);

	// ball drawn over paddles, black elsewhere
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			vga_red <= 1'b0;
			vga_green <= 1'b0;
			vga_blue <= 1'b0;
		end
		else if (on_ball)
		begin
			vga_red <= 1'b1;
			vga_green <= 1'b0;
			vga_blue <= 1'b0;
		end
		else if (on_player)
		begin
			vga_red <= blink_b;
			vga_green <= 1'b1;
			vga_blue <= blink_a;
		end
		else if (on_cpu)
		begin
			vga_red <= ~blink_b;
			vga_green <= ~blink_a;
			vga_blue <= 1'b1;
		end
		else
		begin
			vga_red <= 1'b0;
			vga_green <= 1'b0;
			vga_blue <= 1'b0;
		end
	end

endmodule

// File: pong_pkg.sv
package pong_pkg;

	// counter and coordinate widths
	localparam int coord_w = 11;
	localparam int pos_w = 10;
	localparam int score_w = 8;

	// frame scan, one pixel per clock
	localparam int h_total = 1039;
	localparam int v_total = 665;
	localparam int h_sync_start = 919;
	localparam int v_sync_start = 659;

	// playfield edges
	localparam int field_top = 23;
	localparam int field_left = 104;
	localparam int field_bottom = 623;
	localparam int field_right = 904;

	// object sizes, all given as half extents
	localparam int ball_half = 10;
	localparam int pad_half_w = 50;
	localparam int pad_half_h = 10;
	localparam int catch_half = 60;
	localparam int pad_step = 5;

	// lanes and start positions
	localparam int player_row = field_top + 500;
	localparam int cpu_row = field_top + 100;
	localparam int ball_start_row = field_top + 120;
	localparam int start_col = field_left + 400;
	localparam int top_bounce_row = cpu_row + 2;
	localparam int bottom_row = field_bottom - 102;

	// ball direction codes
	localparam logic [1:0] dir_up_right = 2'd0;
	localparam logic [1:0] dir_up_left = 2'd1;
	localparam logic [1:0] dir_down_left = 2'd2;
	localparam logic [1:0] dir_down_right = 2'd3;

	// score needed for speed levels 1 to 9
	localparam int speed_thresholds [0:8] = '{4, 9, 15, 23, 30, 35, 40, 45, 50};
	// interval shrinks in tenths of the base interval
	localparam int speed_div = 10;
	localparam int blink_steps = 25;

endpackage

// File: pong_properties.sv
`timescale 1ns/100ps

module pong_properties (
	input logic                         clk,
	input logic                         rst,
	input logic                         hit,
	input logic                         miss,
	input logic [pong_pkg::score_w-1:0] score,
	input logic                         hsync,
	input logic [pong_pkg::coord_w-1:0] col
);

	// failed assertions so far
	int error_count = 0;

	// one outcome at a time
	hit_miss_exclusive: assert property (@(posedge clk) disable iff (rst) !(hit && miss))
	else
	begin
		error_count++;
		$error("hit and miss are high in the same cycle");
	end

	// a miss wipes the score on the next clock
	miss_clears_score: assert property (@(posedge clk) disable iff (rst)
		miss |=> (score == '0))
	else
	begin
		error_count++;
		$error("score is not zero the cycle after a miss");
	end

	hsync_in_sync_cols: assert property (@(posedge clk) disable iff (rst)
		!hsync |-> ((col >= pong_pkg::h_sync_start) && (col < pong_pkg::h_total)))
	else
	begin
		error_count++;
		$error("hsync is low outside the sync columns");
	end

endmodule

bind pong_top pong_properties u_pong_properties (
	.clk   (clk),
	.rst   (rst),
	.hit   (hit),
	.miss  (miss),
	.score (score),
	.hsync (vga_hsync),
	.col   (col)
);

// File: pong_top.sv
`timescale 1ns/100ps

module pong_top #(
	parameter int step_base_cycles = 500000
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         left,
	input  logic                         right,
	output logic                         vga_red,
	output logic                         vga_green,
	output logic                         vga_blue,
	output logic                         vga_hsync,
	output logic                         vga_vsync,
	output logic                         hit,
	output logic                         miss,
	output logic [pong_pkg::score_w-1:0] score
);

	logic [pong_pkg::coord_w-1:0] col;
	logic [pong_pkg::coord_w-1:0] row;
	logic                         step;
	logic                         blink_a;
	logic                         blink_b;
	logic [pong_pkg::pos_w-1:0]   pad_col;
	logic [pong_pkg::pos_w-1:0]   ball_row;
	logic [pong_pkg::pos_w-1:0]   ball_col;

	vga_timing u_vga_timing (
		.clk   (clk),
		.rst   (rst),
		.col   (col),
		.row   (row),
		.hsync (vga_hsync),
		.vsync (vga_vsync)
	);

	step_timer #(
		.step_base_cycles (step_base_cycles)
	) u_step_timer (
		.clk     (clk),
		.rst     (rst),
		.score   (score),
		.step    (step),
		.blink_a (blink_a),
		.blink_b (blink_b)
	);

	paddle_ctrl u_paddle_ctrl (
		.clk     (clk),
		.rst     (rst),
		.left    (left),
		.right   (right),
		.step    (step),
		.pad_col (pad_col)
	);

	ball_ctrl u_ball_ctrl (
		.clk      (clk),
		.rst      (rst),
		.step     (step),
		.pad_col  (pad_col),
		.ball_row (ball_row),
		.ball_col (ball_col),
		.hit      (hit),
		.miss     (miss),
		.score    (score)
	);

	pixel_render u_pixel_render (
		.clk       (clk),
		.rst       (rst),
		.col       (col),
		.row       (row),
		.ball_row  (ball_row),
		.ball_col  (ball_col),
		.pad_col   (pad_col),
		.blink_a   (blink_a),
		.blink_b   (blink_b),
		.vga_red   (vga_red),
		.vga_green (vga_green),
		.vga_blue  (vga_blue)
	);

endmodule

// File: step_timer.sv
`timescale 1ns/100ps

module step_timer #(
	parameter int step_base_cycles = 500000
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [pong_pkg::score_w-1:0] score,
	output logic                         step,
	output logic                         blink_a,
	output logic                         blink_b
);

	localparam int cnt_w = $clog2(step_base_cycles + 1);
	localparam int blink_max = pong_pkg::blink_steps * step_base_cycles;
	localparam int blink_w = $clog2(blink_max + 1);

	logic [3:0]         level;
	logic [cnt_w-1:0]   interval_next;
	logic [cnt_w-1:0]   interval;
	logic [cnt_w-1:0]   cnt;
	logic [blink_w-1:0] blink_cnt;

	// speed level is the number of thresholds reached
	always_comb
	begin
		level = '0;
		for (int i = 0; i < $size(pong_pkg::speed_thresholds); i++)
		begin
			if (score >= pong_pkg::speed_thresholds[i])
				level = level + 1'b1;
		end
	end

	assign interval_next = cnt_w'((step_base_cycles * (pong_pkg::speed_div - int'(level)))
		/ pong_pkg::speed_div);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			interval <= cnt_w'(step_base_cycles);
		else
			interval <= interval_next;
	end

	// counter may sit above a freshly shortened interval, so restart on >=
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			cnt <= '0;
		else if (cnt >= interval)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	assign step = (cnt == interval);

	// slow square wave for the paddle colours
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			blink_cnt <= '0;
			blink_a <= 1'b0;
			blink_b <= 1'b0;
		end
		else if (blink_cnt == blink_w'(blink_max))
		begin
			blink_cnt <= '0;
			blink_a <= ~blink_a;
			blink_b <= ~blink_b;
		end
		else
		begin
			blink_cnt <= blink_cnt + 1'b1;
		end
	end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int period_ns = 100
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	always #(period_ns / 2) clk = ~clk;

endmodule

// File: tb_pong.sv
`timescale 1ns/100ps

module tb_pong;

	localparam int drive_delay = 1;
	localparam int frame_cycles = 1040 * 666;
	localparam int flight_cycles = 25000;
	// three frames and three ball flights of tests plus one frame and two flights of margin
	localparam int cycle_limit = 4 * frame_cycles + 5 * flight_cycles;
	// about 40 paddle steps at 21 cycles per step
	localparam int left_hold_cycles = 840;

	logic                         clk;
	logic                         rst;
	logic                         left;
	logic                         right;
	logic                         vga_red;
	logic                         vga_green;
	logic                         vga_blue;
	logic                         vga_hsync;
	logic                         vga_vsync;
	logic                         hit;
	logic                         miss;
	logic [pong_pkg::score_w-1:0] score;
	int                           cycle_count;

	tb_clock_gen #(
		.period_ns (100)
	) u_clock_gen (
		.clk (clk)
	);

	pong_top #(
		.step_base_cycles (20)
	) u_dut (
		.clk       (clk),
		.rst       (rst),
		.left      (left),
		.right     (right),
		.vga_red   (vga_red),
		.vga_green (vga_green),
		.vga_blue  (vga_blue),
		.vga_hsync (vga_hsync),
		.vga_vsync (vga_vsync),
		.hit       (hit),
		.miss      (miss),
		.score     (score)
	);

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout: the run went past %0d cycles without finishing", cycle_limit);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end
	end

	// stop at the first failure of a bound property
	always @(negedge clk)
	begin
		if (u_dut.u_pong_properties.error_count != 0)
		begin
			$display("a bound assertion on the DUT failed");
			$display("Finished with errors");
			$fatal(1, "assertion failure");
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#(drive_delay);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		left = 1'b0;
		right = 1'b0;
		repeat (2) @(posedge clk);
		#(drive_delay);
		rst = 1'b0;
	endtask

	task automatic expect_value(input string test, input int expected, input int actual);
		assert (actual == expected)
		else
		begin
			$display("[FAIL] %s: expected %0d, actual %0d", test, expected, actual);
			$display("Finished with errors");
			$fatal(1, "check failed in %s", test);
		end
	endtask

	function automatic logic sync_level(input logic use_v);
		return use_v ? vga_vsync : vga_hsync;
	endfunction

	// low time and fall to fall period in clock cycles
	task automatic measure_sync(input logic use_v, output int low_len, output int period);
		low_len = 0;
		period = 0;
		while (sync_level(use_v) !== 1'b1)
			next_cycle();
		while (sync_level(use_v) !== 1'b0)
			next_cycle();
		while (sync_level(use_v) === 1'b0)
		begin
			low_len++;
			period++;
			next_cycle();
		end
		while (sync_level(use_v) === 1'b1)
		begin
			period++;
			next_cycle();
		end
	endtask

	task automatic wait_outcome();
		while (!hit && !miss)
			next_cycle();
	endtask

	task automatic hsync_period();
		int low_len;
		int period;
		measure_sync(1'b0, low_len, period);
		expect_value("hsync_period", 120, low_len);
		expect_value("hsync_period", 1040, period);
	endtask

	task automatic vsync_period();
		int low_len;
		int period;
		measure_sync(1'b1, low_len, period);
		expect_value("vsync_period", 6 * 1040, low_len);
		expect_value("vsync_period", frame_cycles, period);
	endtask

	// counters start at 0 when reset falls
	// colour lags the pixel by one clock
	task automatic pixel_colours();
		int  c;
		int  r;
		logic in_pad;
		logic outside;
		c = 0;
		r = 0;
		for (int n = 0; n < frame_cycles; n++)
		begin
			next_cycle();
			// only paddle rows below the lowest ball box
			in_pad = (c >= pong_pkg::start_col - pong_pkg::pad_half_w) &&
				(c <= pong_pkg::start_col + pong_pkg::pad_half_w) &&
				(r > pong_pkg::bottom_row) && (r <= pong_pkg::player_row + pong_pkg::pad_half_h);
			// cpu paddle may hang past the side walls in its own lane
			outside = (r < pong_pkg::field_top) || (r > pong_pkg::field_bottom) ||
				(((c < pong_pkg::field_left) || (c > pong_pkg::field_right)) &&
				((r < pong_pkg::cpu_row - pong_pkg::pad_half_h) ||
				(r > pong_pkg::cpu_row + pong_pkg::pad_half_h)));
			if (in_pad)
				expect_value("pixel_colours", 1, int'(vga_green));
			if (outside)
				expect_value("pixel_colours", 0, int'({vga_red, vga_green, vga_blue}));
			if (c == pong_pkg::h_total)
			begin
				c = 0;
				r = (r == pong_pkg::v_total) ? 0 : r + 1;
			end
			else
			begin
				c++;
			end
		end
	endtask

	// idle paddle at start_col misses the ball near column 870
	task automatic idle_miss();
		wait_outcome();
		expect_value("idle_miss", 1, int'(miss));
		expect_value("idle_miss", 0, int'(hit));
		expect_value("idle_miss", 0, int'(score));
	endtask

	// paddle clamps at 854 within the catch window of the landing column
	task automatic right_catch();
		right = 1'b1;
		wait_outcome();
		expect_value("right_catch", 1, int'(hit));
		expect_value("right_catch", 0, int'(miss));
		while (hit)
			next_cycle();
		next_cycle();
		expect_value("right_catch", 1, int'(score));
	endtask

	// paddle pulled back only part way misses the ball on the far left
	task automatic miss_clears();
		right = 1'b0;
		left = 1'b1;
		repeat (left_hold_cycles) next_cycle();
		left = 1'b0;
		wait_outcome();
		expect_value("miss_clears", 1, int'(miss));
		expect_value("miss_clears", 0, int'(hit));
		next_cycle();
		expect_value("miss_clears", 0, int'(score));
	endtask

	initial
	begin
		rst = 1'b1;
		left = 1'b0;
		right = 1'b0;
		cycle_count = 0;
		apply_reset();
		pixel_colours();
		apply_reset();
		hsync_period();
		vsync_period();
		apply_reset();
		idle_miss();
		apply_reset();
		right_catch();
		miss_clears();
		if (u_dut.u_pong_properties.error_count == 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
		begin
			$display("Finished with errors");
			$fatal(1, "a bound assertion on the DUT failed");
		end
	end

endmodule

// File: vga_timing.sv
`timescale 1ns/100ps

module vga_timing (
	input  logic                         clk,
	input  logic                         rst,
	output logic [pong_pkg::coord_w-1:0] col,
	output logic [pong_pkg::coord_w-1:0] row,
	output logic                         hsync,
	output logic                         vsync
);

	// column runs every clock, row steps on column wrap
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			col <= '0;
			row <= '0;
		end
		else if (col == pong_pkg::h_total)
		begin
			col <= '0;
			if (row == pong_pkg::v_total)
				row <= '0;
			else
				row <= row + 1'b1;
		end
		else
		begin
			col <= col + 1'b1;
		end
	end

	// active low pulses at the end of each line and frame
	assign hsync = ~((col >= pong_pkg::h_sync_start) && (col < pong_pkg::h_total));
	assign vsync = ~((row >= pong_pkg::v_sync_start) && (row < pong_pkg::v_total));

endmodule
